// File: common/issue_pkg.sv
// --------------------
// issue stage package
// widths, unit and operation encodings shared by the stage
// --------------------
package issue_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned XLEN       = 64;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned TRANS_ID_W = 3;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;

  // unit needed by an instruction
  // also the clobber list entry, NONE means no pending writer
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    LOAD      = 4'd1,
    STORE     = 4'd2,
    ALU       = 4'd3,
    CTRL_FLOW = 4'd4,
    MULT      = 4'd5,
    CSR       = 4'd6
  } fu_t;

  // operation code, only carried through to execute
  typedef enum logic [6:0] {
    // integer arithmetic and logic
    ADD, SUB, ADDW, SUBW,
    XORL, ORL, ANDL,
    SRA, SRL, SLL, SRAW, SRLW, SLLW,
    SLTS, SLTU,
    // branches and jumps
    EQ, NE, LTS, GES, LTU, GEU,
    JALR, BRANCH,
    // memory
    LD, SD, LW, LWU, SW, LH, LHU, SH, LB, LBU, SB,
    // multiply and divide
    MUL, MULH, MULHU, MULHSU, MULW,
    DIV, DIVU, DIVW, DIVUW,
    REM, REMU, REMW, REMUW,
    // csr access
    CSR_WRITE, CSR_READ, CSR_SET, CSR_CLEAR
  } fu_op_t;

endpackage

// File: regfile/int_regfile.sv
// --------------------
// integer register file
// 31 writable 64-bit registers, two async read ports, one write port
// --------------------
`timescale 1ns/1ps

module int_regfile
  import issue_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // read ports, combinational
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o,
  // commit write port
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  xlen_t     wdata_i
);

  // x0 has no storage
  xlen_t mem_q [NR_REGS-1:1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NR_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // writes to x0 are dropped here
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // read mux, address 0 is hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

// File: design/operand_hazard_check.sv
// --------------------
// operand hazard check
// raw/waw checks against the clobber list, unit busy and issue ack
// --------------------
`timescale 1ns/1ps

module operand_hazard_check
  import issue_pkg::*;
(
  input  logic                   issue_valid_i,
  input  fu_t                    instr_fu_i,
  input  reg_addr_t              instr_rs1_i,
  input  reg_addr_t              instr_rs2_i,
  input  reg_addr_t              instr_rd_i,
  input  logic                   instr_use_zimm_i,
  input  logic                   instr_ex_valid_i,
  // pending writer per register
  input  fu_t [NR_REGS-1:0]      rd_clobber_i,
  input  logic                   rs1_valid_i,
  input  logic                   rs2_valid_i,
  input  logic                   alu_ready_i,
  input  logic                   lsu_ready_i,
  // commit port, for the same-cycle waw bypass
  input  logic                   we_i,
  input  reg_addr_t              waddr_i,
  // multiplier issued in the previous cycle
  input  logic                   mult_pending_i,
  output logic                   forward_rs1_o,
  output logic                   forward_rs2_o,
  output logic                   issue_ack_o,
  output logic                   stall_issue_o
);

  fu_t  rs1_writer;
  fu_t  rs2_writer;
  fu_t  rd_writer;
  logic operand_stall;
  logic fu_busy;

  assign rs1_writer = rd_clobber_i[instr_rs1_i];
  assign rs2_writer = rd_clobber_i[instr_rs2_i];
  assign rd_writer  = rd_clobber_i[instr_rd_i];

  // only report a stall for a real instruction
  assign stall_issue_o = issue_valid_i & operand_stall;

  // busy flag of the unit this instruction needs
  always_comb begin : fu_busy_sel
    case (instr_fu_i)
      ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~alu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // --------------------
  // raw check
  // --------------------
  // csr results only come back through the register file, never forwarded
  always_comb begin : raw_check
    operand_stall = 1'b0;
    forward_rs1_o = 1'b0;
    forward_rs2_o = 1'b0;
    // zimm in rs1 is an immediate, nothing to wait for
    if (!instr_use_zimm_i && (rs1_writer != NONE)) begin
      if (rs1_valid_i && (rs1_writer != CSR)) begin
        forward_rs1_o = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
    if (rs2_writer != NONE) begin
      if (rs2_valid_i && (rs2_writer != CSR)) begin
        forward_rs2_o = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
  end

  // --------------------
  // issue ack
  // --------------------
  always_comb begin : ack_logic
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      // waw: rd free, or freed by the commit in this very cycle
      if (!operand_stall && !fu_busy) begin
        if ((rd_writer == NONE) || (we_i && (waddr_i == instr_rd_i))) begin
          issue_ack_o = 1'b1;
        end
      end
      // exceptions and no-unit instructions need no operands and no unit
      if (instr_ex_valid_i || (instr_fu_i == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // result bus of the fixed latency group is taken by the multiplier next cycle
    if (mult_pending_i && (instr_fu_i inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

// File: design/operand_select.sv
// --------------------
// operand select
// next-cycle operand a and operand b multiplexers
// --------------------
`timescale 1ns/1ps

module operand_select
  import issue_pkg::*;
(
  // register file read data
  input  xlen_t     rdata_a_i,
  input  xlen_t     rdata_b_i,
  // forwarded results from the scoreboard
  input  xlen_t     rs1_fwd_i,
  input  xlen_t     rs2_fwd_i,
  input  logic      forward_rs1_i,
  input  logic      forward_rs2_i,
  // instruction fields
  input  fu_t       instr_fu_i,
  input  reg_addr_t instr_rs1_i,
  input  xlen_t     instr_imm_i,
  input  xlen_t     instr_pc_i,
  input  logic      instr_use_imm_i,
  input  logic      instr_use_pc_i,
  input  logic      instr_use_zimm_i,
  output xlen_t     operand_a_o,
  output xlen_t     operand_b_o
);

  logic imm_as_b;

  // stores keep rs2 as data, branches compare rs1/rs2 and take imm separately
  assign imm_as_b = instr_use_imm_i && (instr_fu_i != STORE) && (instr_fu_i != CTRL_FLOW);

  // --------------------
  // operand a
  // --------------------
  // later assignments win: zimm over pc over forward over regfile
  always_comb begin : op_a_mux
    operand_a_o = rdata_a_i;
    if (forward_rs1_i) begin
      operand_a_o = rs1_fwd_i;
    end
    if (instr_use_pc_i) begin
      operand_a_o = instr_pc_i;
    end
    if (instr_use_zimm_i) begin
      // csr immediate sits in the rs1 field, zero extended
      operand_a_o = {{(XLEN - REG_ADDR_W){1'b0}}, instr_rs1_i};
    end
  end

  // --------------------
  // operand b
  // --------------------
  always_comb begin : op_b_mux
    operand_b_o = rdata_b_i;
    if (forward_rs2_i) begin
      operand_b_o = rs2_fwd_i;
    end
    if (imm_as_b) begin
      operand_b_o = instr_imm_i;
    end
  end

endmodule

// File: design/issue_dispatch_regs.sv
// --------------------
// issue to execute registers
// operand and field registers plus one-cycle unit valids
// --------------------
`timescale 1ns/1ps

module issue_dispatch_regs
  import issue_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  // handshake edge: valid and ack
  input  logic      issue_fire_i,
  input  logic      instr_ex_valid_i,
  input  fu_t       instr_fu_i,
  input  fu_op_t    instr_op_i,
  input  trans_id_t instr_trans_id_i,
  input  xlen_t     instr_imm_i,
  input  xlen_t     instr_pc_i,
  input  xlen_t     operand_a_i,
  input  xlen_t     operand_b_i,
  // execute side
  output xlen_t     operand_a_o,
  output xlen_t     operand_b_o,
  output xlen_t     imm_o,
  output fu_t       fu_o,
  output fu_op_t    operation_o,
  output trans_id_t trans_id_o,
  output xlen_t     pc_o,
  output logic      alu_valid_o,
  output logic      branch_valid_o,
  output logic      lsu_valid_o,
  output logic      mult_valid_o,
  output logic      csr_valid_o
);

  logic dispatch;

  // exceptions pass through the scoreboard without starting a unit
  assign dispatch = issue_fire_i && !instr_ex_valid_i && !flush_i;

  // --------------------
  // unit valids
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      // pulse for one cycle, fu NONE raises nothing
      alu_valid_o    <= dispatch && (instr_fu_i == ALU);
      branch_valid_o <= dispatch && (instr_fu_i == CTRL_FLOW);
      lsu_valid_o    <= dispatch && (instr_fu_i inside {LOAD, STORE});
      mult_valid_o   <= dispatch && (instr_fu_i == MULT);
      csr_valid_o    <= dispatch && (instr_fu_i == CSR);
    end
  end

  // --------------------
  // payload, loaded every cycle
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      imm_o       <= '0;
      fu_o        <= NONE;
      operation_o <= ADD;
      trans_id_o  <= '0;
      pc_o        <= '0;
    end else begin
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      imm_o       <= instr_imm_i;
      fu_o        <= instr_fu_i;
      operation_o <= instr_op_i;
      trans_id_o  <= instr_trans_id_i;
      pc_o        <= instr_pc_i;
    end
  end

  // --------------------
  // assertions
  // --------------------
  a_one_unit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}))
    else $error("more than one unit valid at once");

  // branch unit compares both operands, they must be resolved
  a_branch_ops_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_valid_o |-> (!$isunknown(operand_a_o) && !$isunknown(operand_b_o)))
    else $error("unknown operand on a branch dispatch");

endmodule

// File: design/issue_read_operands.sv
// --------------------
// issue and operand read stage
// hazard check, register read, operand select and execute hand-off
// --------------------
`timescale 1ns/1ps

module issue_read_operands
  import issue_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  // issue side
  input  logic              issue_valid_i,
  input  fu_t               instr_fu_i,
  input  fu_op_t            instr_op_i,
  input  reg_addr_t         instr_rs1_i,
  input  reg_addr_t         instr_rs2_i,
  input  reg_addr_t         instr_rd_i,
  input  xlen_t             instr_imm_i,
  input  xlen_t             instr_pc_i,
  input  trans_id_t         instr_trans_id_i,
  input  logic              instr_use_imm_i,
  input  logic              instr_use_pc_i,
  input  logic              instr_use_zimm_i,
  input  logic              instr_ex_valid_i,
  output logic              issue_ack_o,
  // scoreboard side
  output reg_addr_t         rs1_o,
  input  xlen_t             rs1_i,
  input  logic              rs1_valid_i,
  output reg_addr_t         rs2_o,
  input  xlen_t             rs2_i,
  input  logic              rs2_valid_i,
  input  fu_t [NR_REGS-1:0] rd_clobber_i,
  // commit side
  input  logic              we_i,
  input  reg_addr_t         waddr_i,
  input  xlen_t             wdata_i,
  // execute side
  input  logic              alu_ready_i,
  input  logic              lsu_ready_i,
  output xlen_t             operand_a_o,
  output xlen_t             operand_b_o,
  output xlen_t             imm_o,
  output fu_t               fu_o,
  output fu_op_t            operation_o,
  output trans_id_t         trans_id_o,
  output xlen_t             pc_o,
  output logic              alu_valid_o,
  output logic              branch_valid_o,
  output logic              lsu_valid_o,
  output logic              mult_valid_o,
  output logic              csr_valid_o,
  output xlen_t             rs1_forwarding_o,
  output xlen_t             rs2_forwarding_o,
  output logic              stall_issue_o
);

  xlen_t rdata_a;
  xlen_t rdata_b;
  xlen_t operand_a_n;
  xlen_t operand_b_n;
  logic  forward_rs1;
  logic  forward_rs2;
  logic  issue_fire;

  // scoreboard is polled with the source addresses
  assign rs1_o = instr_rs1_i;
  assign rs2_o = instr_rs2_i;

  assign issue_fire = issue_valid_i & issue_ack_o;

  // unregistered operands go out for early consumers
  assign rs1_forwarding_o = operand_a_n;
  assign rs2_forwarding_o = operand_b_n;

  int_regfile i_int_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (instr_rs1_i),
    .raddr_b_i (instr_rs2_i),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (we_i),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i)
  );

  // multiplier valid register feeds back for the contention rule
  operand_hazard_check i_operand_hazard_check (
    .issue_valid_i    (issue_valid_i),
    .instr_fu_i       (instr_fu_i),
    .instr_rs1_i      (instr_rs1_i),
    .instr_rs2_i      (instr_rs2_i),
    .instr_rd_i       (instr_rd_i),
    .instr_use_zimm_i (instr_use_zimm_i),
    .instr_ex_valid_i (instr_ex_valid_i),
    .rd_clobber_i     (rd_clobber_i),
    .rs1_valid_i      (rs1_valid_i),
    .rs2_valid_i      (rs2_valid_i),
    .alu_ready_i      (alu_ready_i),
    .lsu_ready_i      (lsu_ready_i),
    .we_i             (we_i),
    .waddr_i          (waddr_i),
    .mult_pending_i   (mult_valid_o),
    .forward_rs1_o    (forward_rs1),
    .forward_rs2_o    (forward_rs2),
    .issue_ack_o      (issue_ack_o),
    .stall_issue_o    (stall_issue_o)
  );

  operand_select i_operand_select (
    .rdata_a_i        (rdata_a),
    .rdata_b_i        (rdata_b),
    .rs1_fwd_i        (rs1_i),
    .rs2_fwd_i        (rs2_i),
    .forward_rs1_i    (forward_rs1),
    .forward_rs2_i    (forward_rs2),
    .instr_fu_i       (instr_fu_i),
    .instr_rs1_i      (instr_rs1_i),
    .instr_imm_i      (instr_imm_i),
    .instr_pc_i       (instr_pc_i),
    .instr_use_imm_i  (instr_use_imm_i),
    .instr_use_pc_i   (instr_use_pc_i),
    .instr_use_zimm_i (instr_use_zimm_i),
    .operand_a_o      (operand_a_n),
    .operand_b_o      (operand_b_n)
  );

  issue_dispatch_regs i_issue_dispatch_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .issue_fire_i     (issue_fire),
    .instr_ex_valid_i (instr_ex_valid_i),
    .instr_fu_i       (instr_fu_i),
    .instr_op_i       (instr_op_i),
    .instr_trans_id_i (instr_trans_id_i),
    .instr_imm_i      (instr_imm_i),
    .instr_pc_i       (instr_pc_i),
    .operand_a_i      (operand_a_n),
    .operand_b_i      (operand_b_n),
    .operand_a_o      (operand_a_o),
    .operand_b_o      (operand_b_o),
    .imm_o            (imm_o),
    .fu_o             (fu_o),
    .operation_o      (operation_o),
    .trans_id_o       (trans_id_o),
    .pc_o             (pc_o),
    .alu_valid_o      (alu_valid_o),
    .branch_valid_o   (branch_valid_o),
    .lsu_valid_o      (lsu_valid_o),
    .mult_valid_o     (mult_valid_o),
    .csr_valid_o      (csr_valid_o)
  );

endmodule

// File: verification/tb_clock_gen.sv
// --------------------
// testbench clock and reset
// 40 ns clock, active-low reset held for three cycles
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verification/issue_read_operands_tb.sv
// --------------------
// issue stage testbench
// reference register model, expected valids and operand checks
// --------------------
`timescale 1ns/1ps

module issue_read_operands_tb
  import issue_pkg::*;
();

  localparam int NR_COMMITS = 26;
  localparam int NR_RANDOM  = 60;
  // reset, commits, random issue and about 50 directed cycles, three times over
  localparam int MAX_CYCLES = 3 * (NR_COMMITS + NR_RANDOM + 50);

  logic clk_i, rst_ni, flush_i;
  logic issue_valid_i, issue_ack_o, stall_issue_o;
  fu_t instr_fu_i, fu_o;
  fu_op_t instr_op_i, operation_o;
  reg_addr_t instr_rs1_i, instr_rs2_i, instr_rd_i, rs1_o, rs2_o, waddr_i;
  xlen_t instr_imm_i, instr_pc_i, rs1_i, rs2_i, wdata_i;
  trans_id_t instr_trans_id_i, trans_id_o;
  logic instr_use_imm_i, instr_use_pc_i, instr_use_zimm_i, instr_ex_valid_i;
  logic rs1_valid_i, rs2_valid_i, we_i, alu_ready_i, lsu_ready_i;
  fu_t [NR_REGS-1:0] rd_clobber_i;
  xlen_t operand_a_o, operand_b_o, imm_o, pc_o, rs1_forwarding_o, rs2_forwarding_o;
  logic alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o;

  // reference model state
  xlen_t ref_regs [NR_REGS];
  logic exp_ack, exp_stall, fire_q, check_q;
  xlen_t exp_a, exp_b, exp_a_q, exp_b_q, exp_pc_q, exp_imm_q;
  fu_t exp_fu_q;
  fu_op_t exp_op_q;
  trans_id_t exp_tid_q;
  logic [4:0] exp_valid_q;
  integer seed;
  int cycles = 0;
  int fail_count = 0;

  tb_clock_gen i_tb_clock_gen (.clk_o(clk_i), .rst_no(rst_ni));

  issue_read_operands i_issue_read_operands (.*);

  // --------------------
  // helpers
  // --------------------
  task automatic fail_run(input string why);
    fail_count++;
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
    fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // {alu, branch, lsu, mult, csr}
  function automatic logic [4:0] unit_onehot(input fu_t fu);
    case (fu)
      ALU:         return 5'b10000;
      CTRL_FLOW:   return 5'b01000;
      LOAD, STORE: return 5'b00100;
      MULT:        return 5'b00010;
      CSR:         return 5'b00001;
      default:     return 5'b00000;
    endcase
  endfunction

  function automatic fu_t pick_fu(input int unsigned sel);
    case (sel % 5)
      0:       return ALU;
      1:       return CTRL_FLOW;
      2:       return LOAD;
      3:       return STORE;
      default: return CSR;
    endcase
  endfunction

  task automatic load_random(input fu_t fu);
    instr_fu_i       = fu;
    // any defined operation code, execute only carries it
    instr_op_i       = fu_op_t'(7'($unsigned($random(seed)) % (int'(CSR_CLEAR) + 1)));
    instr_rs1_i      = 5'($random(seed));
    instr_rs2_i      = 5'($random(seed));
    instr_rd_i       = 5'($random(seed));
    instr_imm_i      = {$random(seed), $random(seed)};
    instr_pc_i       = {$random(seed), $random(seed)};
    instr_trans_id_i = 3'($random(seed));
    instr_use_imm_i  = 1'b0;
    instr_use_pc_i   = 1'b0;
    instr_use_zimm_i = 1'b0;
    instr_ex_valid_i = 1'b0;
  endtask

  // fixed registers for the hazard cases: rs1 x5, rs2 x6, rd x7
  task automatic load_fixed(input fu_t fu);
    load_random(fu);
    instr_rs1_i = 5'd5;
    instr_rs2_i = 5'd6;
    instr_rd_i  = 5'd7;
  endtask

  task automatic clear_clobber();
    for (int i = 0; i < NR_REGS; i++) begin
      rd_clobber_i[i] = NONE;
    end
    rs1_valid_i = 1'b0;
    rs2_valid_i = 1'b0;
  endtask

  // hold valid high from a falling edge until the handshake is seen
  task automatic issue_and_wait();
    issue_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!fire_q);
    issue_valid_i = 1'b0;
  endtask

  // present the instruction for some cycles while no ack is expected
  task automatic hold_without_ack(input int nr_cycles);
    exp_ack       = 1'b0;
    issue_valid_i = 1'b1;
    repeat (nr_cycles) @(negedge clk_i);
    exp_ack = 1'b1;
  endtask

  // --------------------
  // reference model
  // --------------------
  // operand a: zimm, then pc, then forwarded, then register
  always_comb begin : expected_operands
    if (instr_use_zimm_i) begin
      exp_a = {{(XLEN - REG_ADDR_W){1'b0}}, instr_rs1_i};
    end else if (instr_use_pc_i) begin
      exp_a = instr_pc_i;
    end else if (rd_clobber_i[instr_rs1_i] != NONE) begin
      exp_a = rs1_i;
    end else begin
      exp_a = ref_regs[instr_rs1_i];
    end
    if (instr_use_imm_i && (instr_fu_i != STORE) && (instr_fu_i != CTRL_FLOW)) begin
      exp_b = instr_imm_i;
    end else if (rd_clobber_i[instr_rs2_i] != NONE) begin
      exp_b = rs2_i;
    end else begin
      exp_b = ref_regs[instr_rs2_i];
    end
  end

  // x0 is never written, so ref_regs[0] stays zero
  always_ff @(posedge clk_i or negedge rst_ni) begin : model_regs
    if (!rst_ni) begin
      fire_q      <= 1'b0;
      check_q     <= 1'b0;
      exp_valid_q <= '0;
      exp_a_q     <= '0;
      exp_b_q     <= '0;
      exp_pc_q    <= '0;
      exp_imm_q   <= '0;
      exp_fu_q    <= NONE;
      exp_op_q    <= ADD;
      exp_tid_q   <= '0;
      for (int i = 0; i < NR_REGS; i++) begin
        ref_regs[i] <= '0;
      end
    end else begin
      fire_q  <= issue_valid_i && issue_ack_o;
      check_q <= issue_valid_i && exp_ack && !instr_ex_valid_i && !flush_i &&
                 (instr_fu_i != NONE);
      exp_valid_q <= (issue_valid_i && exp_ack && !instr_ex_valid_i && !flush_i) ?
                     unit_onehot(instr_fu_i) : 5'b00000;
      exp_a_q   <= exp_a;
      exp_b_q   <= exp_b;
      exp_pc_q  <= instr_pc_i;
      exp_imm_q <= instr_imm_i;
      exp_fu_q  <= instr_fu_i;
      exp_op_q  <= instr_op_i;
      exp_tid_q <= instr_trans_id_i;
      if (we_i && (waddr_i != '0)) begin
        ref_regs[waddr_i] <= wdata_i;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles, a handshake never completed", cycles));
    end
  end

  // --------------------
  // checks
  // --------------------
  a_unit_valids: assert property (@(posedge clk_i) disable iff (!rst_ni)
    {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o} == exp_valid_q)
    else report_mismatch("alu/branch/lsu/mult/csr valids",
      XLEN'($sampled({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o})),
      XLEN'($sampled(exp_valid_q)));

  a_issue_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_o == (issue_valid_i && exp_ack))
    else report_mismatch("issue_ack_o", XLEN'($sampled(issue_ack_o)),
      XLEN'($sampled(issue_valid_i && exp_ack)));

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_issue_o == (issue_valid_i && exp_stall))
    else report_mismatch("stall_issue_o", XLEN'($sampled(stall_issue_o)),
      XLEN'($sampled(issue_valid_i && exp_stall)));

  a_operand_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_q |-> (operand_a_o == exp_a_q))
    else report_mismatch("operand_a_o", $sampled(operand_a_o), $sampled(exp_a_q));

  a_operand_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_q |-> (operand_b_o == exp_b_q))
    else report_mismatch("operand_b_o", $sampled(operand_b_o), $sampled(exp_b_q));

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_q |-> (pc_o == exp_pc_q))
    else report_mismatch("pc_o", $sampled(pc_o), $sampled(exp_pc_q));

  // payload registers follow the instruction fields every cycle
  a_imm: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imm_o == exp_imm_q)
    else report_mismatch("imm_o", $sampled(imm_o), $sampled(exp_imm_q));

  a_fu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fu_o == exp_fu_q)
    else report_mismatch("fu_o", XLEN'($sampled(fu_o)), XLEN'($sampled(exp_fu_q)));

  a_operation: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operation_o == exp_op_q)
    else report_mismatch("operation_o", XLEN'($sampled(operation_o)),
      XLEN'($sampled(exp_op_q)));

  a_trans_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_id_o == exp_tid_q)
    else report_mismatch("trans_id_o", XLEN'($sampled(trans_id_o)),
      XLEN'($sampled(exp_tid_q)));

  // scoreboard is asked for the source registers of the current instruction
  a_rs1_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs1_o == instr_rs1_i)
    else report_mismatch("rs1_o", XLEN'($sampled(rs1_o)), XLEN'($sampled(instr_rs1_i)));

  a_rs2_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs2_o == instr_rs2_i)
    else report_mismatch("rs2_o", XLEN'($sampled(rs2_o)), XLEN'($sampled(instr_rs2_i)));

  // unregistered operands of an instruction that is taken
  a_rs1_forwarding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_i && exp_ack) |-> (rs1_forwarding_o == exp_a))
    else report_mismatch("rs1_forwarding_o", $sampled(rs1_forwarding_o), $sampled(exp_a));

  a_rs2_forwarding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_i && exp_ack) |-> (rs2_forwarding_o == exp_b))
    else report_mismatch("rs2_forwarding_o", $sampled(rs2_forwarding_o), $sampled(exp_b));

  // --------------------
  // stimulus
  // --------------------
  initial begin : stimulus
    seed          = 18543;
    issue_valid_i = 1'b0;
    flush_i       = 1'b0;
    we_i          = 1'b0;
    waddr_i       = '0;
    wdata_i       = '0;
    rs1_i         = '0;
    rs2_i         = '0;
    alu_ready_i   = 1'b1;
    lsu_ready_i   = 1'b1;
    exp_ack       = 1'b1;
    exp_stall     = 1'b0;
    clear_clobber();
    load_random(ALU);
    @(posedge rst_ni);
    @(negedge clk_i);

    // commit writes, the first one to x0
    for (int i = 0; i < NR_COMMITS; i++) begin
      we_i    = 1'b1;
      waddr_i = (i == 0) ? 5'd0 : 5'($random(seed));
      wdata_i = {$random(seed), $random(seed)};
      @(negedge clk_i);
    end
    we_i = 1'b0;
    load_fixed(ALU);
    instr_rs1_i = 5'd0;
    instr_rs2_i = 5'd0;
    issue_and_wait();

    // back-to-back instructions with a clean clobber list
    for (int i = 0; i < NR_RANDOM; i++) begin
      load_random(pick_fu($unsigned($random(seed))));
      instr_use_imm_i = 1'($random(seed));
      issue_and_wait();
    end

    // forwarding from alu and load writers
    load_fixed(ALU);
    rd_clobber_i[5] = ALU;
    rd_clobber_i[6] = LOAD;
    rs1_valid_i     = 1'b1;
    rs2_valid_i     = 1'b1;
    rs1_i           = {$random(seed), $random(seed)};
    rs2_i           = {$random(seed), $random(seed)};
    issue_and_wait();
    // csr writer cannot be forwarded
    rd_clobber_i[5] = CSR;
    exp_stall       = 1'b1;
    hold_without_ack(3);
    rd_clobber_i[5] = NONE;
    exp_stall       = 1'b0;
    issue_and_wait();
    // writer known but value not yet available
    rd_clobber_i[5] = ALU;
    rs1_valid_i     = 1'b0;
    exp_stall       = 1'b1;
    hold_without_ack(2);
    rs1_valid_i = 1'b1;
    exp_stall   = 1'b0;
    issue_and_wait();
    clear_clobber();

    // waw, released by a commit to rd in the same cycle
    rd_clobber_i[7] = ALU;
    hold_without_ack(2);
    we_i    = 1'b1;
    waddr_i = 5'd7;
    wdata_i = {$random(seed), $random(seed)};
    issue_and_wait();
    we_i = 1'b0;
    clear_clobber();

    // unit back-pressure
    alu_ready_i = 1'b0;
    hold_without_ack(3);
    alu_ready_i = 1'b1;
    issue_and_wait();
    load_fixed(LOAD);
    lsu_ready_i = 1'b0;
    hold_without_ack(3);
    lsu_ready_i = 1'b1;
    issue_and_wait();

    // exception passes even with the unit busy, no valid follows
    load_fixed(ALU);
    instr_ex_valid_i = 1'b1;
    alu_ready_i      = 1'b0;
    issue_and_wait();
    alu_ready_i = 1'b1;
    load_fixed(NONE);
    issue_and_wait();

    // multiplier contention, alu blocked one cycle, load not blocked
    load_fixed(MULT);
    issue_and_wait();
    load_fixed(ALU);
    hold_without_ack(1);
    issue_and_wait();
    load_fixed(MULT);
    issue_and_wait();
    load_fixed(LOAD);
    issue_and_wait();

    // flush on the handshake edge
    load_fixed(ALU);
    flush_i = 1'b1;
    issue_and_wait();
    flush_i = 1'b0;

    // pc and zimm as operand a
    load_fixed(ALU);
    instr_use_pc_i = 1'b1;
    issue_and_wait();
    load_fixed(CSR);
    instr_use_zimm_i = 1'b1;
    rd_clobber_i[5]  = ALU;
    issue_and_wait();
    clear_clobber();

    repeat (3) @(negedge clk_i);
    if (fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("checks failed before the end of the run");
    end
  end

endmodule

// File: tb.f
common/issue_pkg.sv
regfile/int_regfile.sv
design/operand_hazard_check.sv
design/operand_select.sv
design/issue_dispatch_regs.sv
design/issue_read_operands.sv
verification/tb_clock_gen.sv
verification/issue_read_operands_tb.sv

// File: Makefile
# Verilator build for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_read_operands_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
